// ==== snes_cart_pkg.sv ====
// ========================================
// Types and constants for cartridge
// identification and the work-memory front
// Download addresses are byte addresses and
// download words are 16 bits, low byte first
// CPU-side memory buses use active-high strobes
// ========================================
package snes_cart_pkg;

	// ========================================
	// Download stream
	// ========================================
	localparam int DL_ADDR_W      = 25;
	localparam int DL_DATA_W      = 16;
	localparam int FILE_SIZE_LO_W = 10;

	typedef struct packed {
		logic                 wr;
		logic [DL_ADDR_W-1:0] addr;
		logic [DL_DATA_W-1:0] data;
	} dl_word_t;

	typedef enum logic [1:0] {
		LAYOUT_LOROM   = 2'd0,
		LAYOUT_HIROM   = 2'd1,
		LAYOUT_EXHIROM = 2'd2,
		LAYOUT_AUTO    = 2'd3
	} rom_layout_t;

	// Low 15 bits of the internal header fields
	localparam logic [14:0] HDR_MAPPER    = 15'h7FD4;
	localparam logic [14:0] HDR_TYPE_SIZE = 15'h7FD6;
	localparam logic [14:0] HDR_RAM_SIZE  = 15'h7FD8;
	localparam logic [14:0] HDR_COMPANY   = 15'h7FDA;

	// Address bits 23..15 of the bank holding the header
	localparam logic [8:0] LOROM_PREFIX   = 9'h000;
	localparam logic [8:0] HIROM_PREFIX   = 9'h001;
	localparam logic [8:0] EXHIROM_PREFIX = 9'h081;

	// Mapper bytes
	localparam logic [7:0] MAP_LO_SLOW = 8'h20;
	localparam logic [7:0] MAP_LO_FAST = 8'h30;
	localparam logic [7:0] MAP_LO_EX   = 8'h32;
	localparam logic [7:0] MAP_HI_SLOW = 8'h21;
	localparam logic [7:0] MAP_HI_FAST = 8'h31;
	localparam logic [7:0] MAP_SA1     = 8'h23;

	// Upper nibble of the cartridge type code
	localparam logic [3:0] COP_DSP1  = 4'h8;
	localparam logic [3:0] COP_DSP2  = 4'h9;
	localparam logic [3:0] COP_DSP3  = 4'hA;
	localparam logic [3:0] COP_DSP4  = 4'hB;
	localparam logic [3:0] COP_OBC1  = 4'hC;
	localparam logic [3:0] COP_SDD1  = 4'h5;
	localparam logic [3:0] COP_ST0XX = 4'h8;
	localparam logic [3:0] COP_GSU   = 4'h7;
	localparam logic [3:0] COP_SA1   = 4'h6;

	// ========================================
	// Identification result
	// ========================================
	localparam int          MASK_W       = 24;
	localparam logic [23:0] KIB          = 24'd1024;
	localparam logic [3:0]  ROM_MIN_SIZE = 4'd7;
	localparam logic [3:0]  ROM_DEF_SIZE = 4'd12;
	localparam logic [3:0]  GSU_RAM_SIZE = 4'd6;

	typedef struct packed {
		logic [7:0]  mapper;
		logic [7:0]  chip_type;
		logic [3:0]  rom_size;
		logic [3:0]  ram_size;
		logic [7:0]  company;
		rom_layout_t layout;
	} hdr_fields_t;

	typedef struct packed {
		logic [7:0]        type_code;
		logic [MASK_W-1:0] rom_mask;
		logic [MASK_W-1:0] ram_mask;
	} cart_info_t;

	// ========================================
	// CPU-side memory buses
	// ========================================
	localparam int BUS_DATA_W  = 8;
	// Chip enable, read, write and data bits
	localparam int BUS_FIXED_W = 3 + BUS_DATA_W;
	localparam int WRAM_AW     = 17;
	localparam int ARAM_AW     = 16;
	localparam int BSRAM_AW    = 20;

	typedef struct packed {
		logic                  ce;
		logic                  rd;
		logic                  wr;
		logic [WRAM_AW-1:0]    addr;
		logic [BUS_DATA_W-1:0] data;
	} wram_bus_t;

	typedef struct packed {
		logic                  ce;
		logic                  rd;
		logic                  wr;
		logic [ARAM_AW-1:0]    addr;
		logic [BUS_DATA_W-1:0] data;
	} aram_bus_t;

	typedef struct packed {
		logic                  ce;
		logic                  rd;
		logic                  wr;
		logic [BSRAM_AW-1:0]   addr;
		logic [BUS_DATA_W-1:0] data;
	} bsram_bus_t;

endpackage

// ==== cart_header_scan.sv ====
// ========================================
// Header capture from the ROM download
// Both edges of the write strobe mark a beat
// A 512-byte copier header is removed using
// the low 10 bits of the file size
// Auto layout tries LoROM, then HiROM
// ========================================
module cart_header_scan
	import snes_cart_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download,
	input  dl_word_t                  beat,
	input  logic [FILE_SIZE_LO_W-1:0] file_size_lo,
	input  rom_layout_t               layout,
	output hdr_fields_t               hdr
);

	logic                 wr_prev;
	logic                 beat_hit;
	logic [DL_ADDR_W-1:0] eff_addr;
	logic [8:0]           sel_prefix;
	logic                 is_auto;
	logic                 lo_ok;
	logic                 hit_mapper;
	logic                 hit_type_size;
	logic                 hit_ram_size;
	logic                 hit_company;

	// Match one header field at the chosen or detected bank
	function automatic logic field_hit(
		input logic [DL_ADDR_W-1:0] a,
		input logic [8:0]           pfx,
		input logic                 auto_mode,
		input logic                 lo_valid,
		input logic [14:0]          off
	);
		if (auto_mode)
			return (a == {1'b0, LOROM_PREFIX, off}) ||
				(!lo_valid && a == {1'b0, HIROM_PREFIX, off});
		return a == {1'b0, pfx, off};
	endfunction

	assign beat_hit = download && (beat.wr ^ wr_prev);
	assign eff_addr = beat.addr - {{(DL_ADDR_W-FILE_SIZE_LO_W){1'b0}}, file_size_lo};
	assign is_auto  = (layout == LAYOUT_AUTO);

	assign sel_prefix = (layout == LAYOUT_EXHIROM) ? EXHIROM_PREFIX :
		(layout == LAYOUT_HIROM) ? HIROM_PREFIX : LOROM_PREFIX;

	// Mapper bytes that only a LoROM image holds at 0x7FD4
	assign lo_ok = hdr.mapper inside {MAP_LO_SLOW, MAP_LO_FAST, MAP_LO_EX};

	assign hit_mapper    = field_hit(eff_addr, sel_prefix, is_auto, lo_ok, HDR_MAPPER);
	assign hit_type_size = field_hit(eff_addr, sel_prefix, is_auto, lo_ok, HDR_TYPE_SIZE);
	assign hit_ram_size  = field_hit(eff_addr, sel_prefix, is_auto, lo_ok, HDR_RAM_SIZE);
	assign hit_company   = field_hit(eff_addr, sel_prefix, is_auto, lo_ok, HDR_COMPANY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_prev <= 1'b0;
			hdr     <= '0;
		end else begin
			wr_prev <= beat.wr;
			if (beat_hit) begin
				// Start of a new image
				if (beat.addr == '0) begin
					hdr.ram_size <= 4'h0;
					hdr.layout   <= layout;
				end

				// Detected layout follows the last mapper byte seen
				if (is_auto)
					hdr.layout <= lo_ok ? LAYOUT_LOROM : LAYOUT_HIROM;

				if (hit_mapper)
					hdr.mapper <= beat.data[15:8];
				if (hit_type_size)
					{hdr.rom_size, hdr.chip_type} <= beat.data[11:0];
				if (hit_ram_size)
					hdr.ram_size <= beat.data[3:0];
				if (hit_company)
					hdr.company <= beat.data[7:0];
			end
		end
	end

endmodule

// ==== cart_chip_classify.sv ====
// ========================================
// Cartridge type code and memory masks
// Result is held from reset until the first
// download ends, then tracks the header
// every cycle while download is low
// ========================================
module cart_chip_classify
	import snes_cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        download,
	input  hdr_fields_t hdr,
	output cart_info_t  info
);

	logic              loaded;
	logic [3:0]        cop;
	logic              st_bit;
	logic              gsu;
	logic [3:0]        rom_exp;
	logic [3:0]        ram_exp;
	logic [MASK_W-1:0] rom_mask_n;
	logic [MASK_W-1:0] ram_mask_n;

	// ========================================
	// Coprocessor detection, first match wins
	// ========================================
	always_comb begin
		cop    = 4'h0;
		st_bit = 1'b0;
		gsu    = 1'b0;
		if (hdr.mapper == MAP_LO_FAST && hdr.chip_type == 8'h05 && hdr.company == 8'hB2)
			cop = COP_DSP3;
		else if (((hdr.mapper == MAP_LO_SLOW || hdr.mapper == MAP_HI_SLOW) &&
				hdr.chip_type == 8'h03) ||
				(hdr.mapper == MAP_LO_FAST && hdr.chip_type == 8'h05) ||
				(hdr.mapper == MAP_HI_FAST && hdr.chip_type inside {8'h03, 8'h05}))
			cop = COP_DSP1;
		else if (hdr.mapper == MAP_LO_SLOW && hdr.chip_type == 8'h05)
			cop = COP_DSP2;
		else if (hdr.mapper == MAP_LO_FAST && hdr.chip_type == 8'h03)
			cop = COP_DSP4;
		else if (hdr.mapper == MAP_LO_FAST && hdr.chip_type == 8'h25)
			cop = COP_OBC1;
		else if (hdr.mapper == MAP_LO_EX && hdr.chip_type inside {8'h43, 8'h45})
			cop = COP_SDD1;
		else if (hdr.mapper == MAP_LO_FAST && hdr.chip_type == 8'hF6) begin
			cop    = COP_ST0XX;
			st_bit = 1'b1;
			// Small ST0XX images use the other variant
			cop[1] = (hdr.rom_size < 4'd10);
		end else if (hdr.mapper == MAP_LO_SLOW &&
				hdr.chip_type inside {8'h13, 8'h14, 8'h15, 8'h1A}) begin
			cop = COP_GSU;
			gsu = 1'b1;
		end else if (hdr.mapper == MAP_SA1 && hdr.chip_type inside {8'h32, 8'h34, 8'h35})
			cop = COP_SA1;
	end

	// Size fields are log2 of the size in KiB
	assign rom_exp    = (hdr.rom_size < ROM_MIN_SIZE) ? ROM_DEF_SIZE : hdr.rom_size;
	assign ram_exp    = gsu ? GSU_RAM_SIZE : hdr.ram_size;
	assign rom_mask_n = (KIB << rom_exp) - 24'd1;
	assign ram_mask_n = (ram_exp == 4'h0) ? '0 : (KIB << ram_exp) - 24'd1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loaded <= 1'b0;
			info   <= '0;
		end else if (download) begin
			loaded <= 1'b1;
		end else if (loaded) begin
			info.type_code <= {cop, st_bit, 1'b0, hdr.layout};
			info.rom_mask  <= rom_mask_n;
			info.ram_mask  <= ram_mask_n;
		end
	end

endmodule

// ==== mem_req_channel.sv ====
// ========================================
// Byte-strobe bus to toggle requests
// No acknowledge, a new request replaces
// the previous one
// bus_t needs ce, rd, wr, addr and 8-bit data
// ========================================
module mem_req_channel
	import snes_cart_pkg::*;
#(
	parameter type bus_t = wram_bus_t,
	localparam int ADDR_W = $bits(bus_t) - BUS_FIXED_W
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  bus_t                  bus,
	output logic                  req,
	output logic                  we,
	output logic [ADDR_W-1:0]     addr,
	output logic [BUS_DATA_W-1:0] data
);

	logic rd;
	logic wr;
	logic rd_q;
	logic wr_q;
	logic new_word;
	logic fire;

	assign rd = bus.ce & bus.rd;
	assign wr = bus.ce & bus.wr;

	// Controller fetches words, so only a word change needs a new read
	assign new_word = (bus.addr[ADDR_W-1:1] != addr[ADDR_W-1:1]);
	assign fire     = (rd & ~rd_q) | (wr & ~wr_q) | (rd & new_word);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
			req  <= 1'b0;
			we   <= 1'b0;
		end else begin
			rd_q <= rd;
			wr_q <= wr;
			if (fire) begin
				req <= ~req;
				// Same value the write strobe register takes now
				we  <= wr;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fire) begin
			addr <= bus.addr;
			data <= bus.data;
		end
	end

endmodule

// ==== cart_mem_front.sv ====
// ========================================
// Cartridge identification and the WRAM,
// ARAM and save RAM request channels
// Requests are toggles, any change of a
// req output is one memory access
// ========================================
module cart_mem_front
	import snes_cart_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download,
	input  dl_word_t                  beat,
	input  logic [FILE_SIZE_LO_W-1:0] file_size_lo,
	input  rom_layout_t               layout,
	input  wram_bus_t                 wram_bus,
	input  aram_bus_t                 aram_bus,
	input  bsram_bus_t                bsram_bus,
	output cart_info_t                info,
	output logic                      wram_req,
	output logic                      wram_we,
	output logic [WRAM_AW-1:0]        wram_addr,
	output logic [BUS_DATA_W-1:0]     wram_data,
	output logic                      aram_req,
	output logic                      aram_we,
	output logic [ARAM_AW-1:0]        aram_addr,
	output logic [BUS_DATA_W-1:0]     aram_data,
	output logic                      bsram_req,
	output logic                      bsram_we,
	output logic [BSRAM_AW-1:0]       bsram_addr,
	output logic [BUS_DATA_W-1:0]     bsram_data
);

	hdr_fields_t hdr;

	// ========================================
	// Cartridge identification
	// ========================================
	cart_header_scan u_scan (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download     (download),
		.beat         (beat),
		.file_size_lo (file_size_lo),
		.layout       (layout),
		.hdr          (hdr)
	);

	cart_chip_classify u_classify (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.download (download),
		.hdr      (hdr),
		.info     (info)
	);

	// ========================================
	// Memory request channels
	// ========================================
	mem_req_channel #(.bus_t(wram_bus_t)) u_wram (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (wram_bus),
		.req     (wram_req),
		.we      (wram_we),
		.addr    (wram_addr),
		.data    (wram_data)
	);

	mem_req_channel #(.bus_t(aram_bus_t)) u_aram (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (aram_bus),
		.req     (aram_req),
		.we      (aram_we),
		.addr    (aram_addr),
		.data    (aram_data)
	);

	mem_req_channel #(.bus_t(bsram_bus_t)) u_bsram (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bsram_bus),
		.req     (bsram_req),
		.we      (bsram_we),
		.addr    (bsram_addr),
		.data    (bsram_data)
	);

endmodule

// ==== tb_cart_mem_front.sv ====
// ========================================
// Trace-driven testbench for cart_mem_front
// Reads cart_trace.txt from the project root
// Inputs change on the falling clock edge,
// outputs are checked on the falling edge
// ========================================
module tb_cart_mem_front;
	import snes_cart_pkg::*;

	logic                      clk_sys;
	logic                      reset;
	logic                      download;
	dl_word_t                  beat;
	logic [FILE_SIZE_LO_W-1:0] file_size_lo;
	rom_layout_t               layout;
	wram_bus_t                 wram_bus;
	aram_bus_t                 aram_bus;
	bsram_bus_t                bsram_bus;
	cart_info_t                info;
	logic                      wram_req;
	logic                      wram_we;
	logic [WRAM_AW-1:0]        wram_addr;
	logic [BUS_DATA_W-1:0]     wram_data;
	logic                      aram_req;
	logic                      aram_we;
	logic [ARAM_AW-1:0]        aram_addr;
	logic [BUS_DATA_W-1:0]     aram_data;
	logic                      bsram_req;
	logic                      bsram_we;
	logic [BSRAM_AW-1:0]       bsram_addr;
	logic [BUS_DATA_W-1:0]     bsram_data;

	int req_count [3];
	int n_records;
	int n_tests;
	int n_fail;
	bit trace_counted;

	cart_mem_front u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Every change of a toggle is one request
	always @(wram_req) if (!reset) req_count[0]++;
	always @(aram_req) if (!reset) req_count[1]++;
	always @(bsram_req) if (!reset) req_count[2]++;

	task automatic check_value(input string name, input string field,
			input logic [63:0] exp, input logic [63:0] got, inout bit ok);
		assert (got === exp) else begin
			$display("error %s %s expected %h actual %h", name, field, exp, got);
			ok = 1'b0;
		end
	endtask

	task automatic finish_test(input string name, input bit ok);
		n_tests++;
		if (ok) begin
			$display("test %s passed", name);
		end else begin
			n_fail++;
			$display("test %s failed", name);
		end
	endtask

	task automatic run_record(input string line);
		string         cmd;
		string         name;
		logic [31:0]   a, b, c, d, e;
		int            ch;
		bit            ok;
		logic [63:0]   got_addr;
		logic          got_we;
		logic [7:0]    got_data;
		ok = 1'b1;
		void'($sscanf(line, "%s", cmd));
		if (cmd == "L") begin
			void'($sscanf(line, "%s %h", cmd, a));
			layout = rom_layout_t'(a[1:0]);
			@(negedge clk_sys);
		end else if (cmd == "F") begin
			void'($sscanf(line, "%s %h", cmd, a));
			file_size_lo = a[FILE_SIZE_LO_W-1:0];
			@(negedge clk_sys);
		end else if (cmd == "D") begin
			void'($sscanf(line, "%s %h", cmd, a));
			download = a[0];
			@(negedge clk_sys);
		end else if (cmd == "B") begin
			void'($sscanf(line, "%s %h %h", cmd, a, b));
			// Either edge of the strobe is a beat
			beat.wr   = ~beat.wr;
			beat.addr = a[DL_ADDR_W-1:0];
			beat.data = b[DL_DATA_W-1:0];
			@(negedge clk_sys);
			repeat ($urandom % 4) @(negedge clk_sys);
		end else if (cmd == "W") begin
			void'($sscanf(line, "%s %d %h %h %h %h %h", cmd, ch, a, b, c, d, e));
			case (ch)
				0: wram_bus = {a[0], b[0], c[0], d[WRAM_AW-1:0], e[7:0]};
				1: aram_bus = {a[0], b[0], c[0], d[ARAM_AW-1:0], e[7:0]};
				default: bsram_bus = {a[0], b[0], c[0], d[BSRAM_AW-1:0], e[7:0]};
			endcase
			@(negedge clk_sys);
		end else if (cmd == "I") begin
			void'($sscanf(line, "%s %h %h %h %s", cmd, a, b, c, name));
			check_value(name, "type_code", a[7:0], info.type_code, ok);
			check_value(name, "rom_mask", b[23:0], info.rom_mask, ok);
			check_value(name, "ram_mask", c[23:0], info.ram_mask, ok);
			finish_test(name, ok);
		end else if (cmd == "C") begin
			void'($sscanf(line, "%s %d %d %h %h %h %s", cmd, ch, a, b, c, d, name));
			case (ch)
				0: begin
					got_addr = wram_addr;
					got_we   = wram_we;
					got_data = wram_data;
				end
				1: begin
					got_addr = aram_addr;
					got_we   = aram_we;
					got_data = aram_data;
				end
				default: begin
					got_addr = bsram_addr;
					got_we   = bsram_we;
					got_data = bsram_data;
				end
			endcase
			check_value(name, "toggles", a, req_count[ch], ok);
			check_value(name, "addr", b, got_addr, ok);
			check_value(name, "we", c[0], got_we, ok);
			check_value(name, "data", d[7:0], got_data, ok);
			finish_test(name, ok);
		end else if (cmd == "Q") begin
			void'($sscanf(line, "%s %s", cmd, name));
			check_value(name, "req", 0, {wram_req, aram_req, bsram_req}, ok);
			check_value(name, "we", 0, {wram_we, aram_we, bsram_we}, ok);
			check_value(name, "info", 0, info, ok);
			finish_test(name, ok);
		end else begin
			$display("unknown trace record %s", cmd);
			n_fail++;
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int    fd;
		int    code;
		string line;
		reset        = 1'b1;
		download     = 1'b0;
		beat         = '0;
		file_size_lo = '0;
		layout       = LAYOUT_LOROM;
		wram_bus     = '0;
		aram_bus     = '0;
		bsram_bus    = '0;
		n_records    = 0;
		n_tests      = 0;
		n_fail       = 0;
		foreach (req_count[i]) req_count[i] = 0;
		void'($urandom(32'hacf5));
		fd = $fopen("cart_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file cart_trace.txt");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#")
					n_records++;
			end
			$fclose(fd);
			trace_counted = 1'b1;
			fd = $fopen("cart_trace.txt", "r");
			repeat (2) @(negedge clk_sys);
			reset = 1'b0;
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#")
					run_record(line);
			end
			$fclose(fd);
			$display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_fail, n_fail);
			if (n_fail == 0 && n_tests > 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

	// Each record gets up to four clock periods
	initial begin
		wait (trace_counted && n_records > 0);
		#(40 * n_records * 4);
		$display("timeout, the trace did not finish in time");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== cart_trace.txt ====
# L layout | F file_size_lo | D download | B addr data | W ch ce rd wr addr data
# I type rom_mask ram_mask name | C ch toggles addr we data name | Q name
Q reset_state
L 0
F 000
D 1
B 0000000 0000
B 0007FD4 2000
B 0007FD6 0A00
B 0007FD8 0003
B 0007FDA 0001
D 0
I 00 0FFFFF 001FFF lorom_manual
L 3
F 200
D 1
B 0000000 0000
B 00081D4 0000
B 00101D4 3100
B 00101D6 0B00
B 00101D8 0005
B 00101DA 0033
D 0
I 01 1FFFFF 007FFF hirom_auto_copier
L 0
F 000
D 1
B 0000000 0000
B 0007FD4 2000
B 0007FD6 0903
B 0007FD8 0000
B 0007FDA 0001
D 0
I 80 07FFFF 000000 dsp1_detect
D 1
B 0000000 0000
B 0007FD6 0513
B 0007FD8 0002
D 0
I 70 3FFFFF 00FFFF gsu_ram_force
W 0 1 1 0 00100 00
W 0 1 1 0 00101 00
C 0 1 00100 0 00 wram_read_burst
W 0 1 1 0 00202 00
C 0 2 00202 0 00 wram_new_word
W 0 0 0 0 00202 00
W 0 1 0 1 1ABCD 5A
W 0 0 0 0 1ABCD 5A
C 0 3 1ABCD 1 5A wram_write
W 1 1 1 0 FFFE 11
W 1 1 1 0 FFFF 11
C 1 1 FFFE 0 11 aram_read
W 1 1 0 1 8001 A5
C 1 2 8001 1 A5 aram_write
W 2 1 1 0 FFFFE 22
W 2 1 1 0 80000 22
C 2 2 80000 0 22 bsram_new_word
W 2 1 0 1 FFFFF C3
C 2 3 FFFFF 1 C3 bsram_write

// ==== files.f ====
snes_cart_pkg.sv
cart_header_scan.sv
cart_chip_classify.sv
mem_req_channel.sv
cart_mem_front.sv
tb_cart_mem_front.sv

// ==== Bender.yml ====
package:
  name: cart_mem_front

sources:
  - snes_cart_pkg.sv
  - cart_header_scan.sv
  - cart_chip_classify.sv
  - mem_req_channel.sv
  - cart_mem_front.sv
  - target: simulation
    files:
      - tb_cart_mem_front.sv
